/* all.f */
common/panel_pkg.sv
verilog/cmd_dispatch.sv
verilog/frame_loader.sv
verilog/pixel_writer.sv
framebuffer/framebuffer_ram.sv
framebuffer/frame_scanout.sv
verilog/panel_cmd_top.sv
tb/panel_cmd_properties.sv
tb/panel_cmd_tb.sv

/* common/panel_pkg.sv */
//////////////////////////////
// Field widths bound the size parameters set on the top level.
// Row 31, column 31 and byte 3 are the largest addresses.
//////////////////////////////
package panel_pkg;

    localparam int ROW_BITS  = 5;
    localparam int COL_BITS  = 5;
    localparam int BYTE_BITS = 2;
    localparam int ADDR_BITS = ROW_BITS + COL_BITS + BYTE_BITS;

    typedef logic [ROW_BITS-1:0]  row_addr_t;
    typedef logic [COL_BITS-1:0]  col_addr_t;
    typedef logic [BYTE_BITS-1:0] byte_addr_t;

    // Row is the most significant field.
    typedef struct packed {
        row_addr_t  row;
        col_addr_t  col;
        byte_addr_t pix_byte;
    } fb_addr_t;

    // The RAM indexes by the flat view, the rest by fields.
    typedef union packed {
        fb_addr_t              fields;
        logic [ADDR_BITS-1:0]  index;
    } fb_addr_u;

    typedef struct packed {
        logic       en;
        fb_addr_u   addr;
        logic [7:0] data;
    } ram_wr_t;

    typedef struct packed {
        fb_addr_u   addr;
        logic [7:0] data;
        logic       last;   // Final beat of a frame.
    } scan_beat_t;

    localparam logic [7:0] OPC_LOAD_FRAME = 8'h01;
    localparam logic [7:0] OPC_SET_PIXEL  = 8'h02;
    localparam logic [7:0] OPC_SHOW       = 8'h03;

endpackage

/* framebuffer/frame_scanout.sv */
//////////////////////////////
// Streams valid addresses only, ascending. Beats hold under back-pressure.
//////////////////////////////
`timescale 1ns/1ps

module frame_scanout #(
    parameter int PIXEL_HEIGHT    = 16,
    parameter int PIXEL_WIDTH     = 16,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    output logic                  busy,
    output panel_pkg::fb_addr_u   rd_addr,
    input  logic [7:0]            rd_data,
    output panel_pkg::scan_beat_t scan_out,
    output logic                  scan_valid,
    input  logic                  scan_ready
);

    localparam panel_pkg::fb_addr_t LAST_ADDR = '{
        row:      panel_pkg::row_addr_t'(PIXEL_HEIGHT - 1),
        col:      panel_pkg::col_addr_t'(PIXEL_WIDTH - 1),
        pix_byte: panel_pkg::byte_addr_t'(BYTES_PER_PIXEL - 1)
    };

    panel_pkg::fb_addr_t   cur;
    logic                  walking;
    logic                  in_flight;
    logic                  issue;
    logic                  pop;
    logic                  cur_last;
    logic            [1:0] count;
    panel_pkg::fb_addr_u   tag_addr;
    logic                  tag_last;
    panel_pkg::scan_beat_t entry0;
    panel_pkg::scan_beat_t entry1;
    panel_pkg::scan_beat_t incoming;

    assign rd_addr    = panel_pkg::fb_addr_u'(cur);
    assign cur_last   = (cur == LAST_ADDR);
    assign scan_valid = (count != 2'd0);
    assign scan_out   = entry0;
    assign pop        = scan_valid && scan_ready;
    assign busy       = walking || in_flight || scan_valid;
    // Buffered beats plus the read in flight stay within two.
    assign issue = walking && (({1'b0, count} + {2'b0, in_flight} - {2'b0, pop}) < 3'd2);

    //////////////////////////////
    // Address walker.
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            walking   <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            in_flight <= issue;
            if (start && !busy) walking <= 1'b1;
            else if (issue && cur_last) walking <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            cur <= '0;
        end else if (issue) begin
            if (cur.pix_byte != LAST_ADDR.pix_byte) begin
                cur.pix_byte <= cur.pix_byte + 1'b1;
            end else begin
                cur.pix_byte <= '0;
                if (cur.col != LAST_ADDR.col) begin
                    cur.col <= cur.col + 1'b1;
                end else begin
                    cur.col <= '0;
                    cur.row <= cur.row + 1'b1;
                end
            end
        end
        if (issue) begin
            tag_addr <= panel_pkg::fb_addr_u'(cur);   // Travels with the read.
            tag_last <= cur_last;
        end
    end

    //////////////////////////////
    // Two-entry skid buffer.
    //////////////////////////////
    assign incoming = '{addr: tag_addr, data: rd_data, last: tag_last};

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 2'd0;
        end else begin
            count <= count + {1'b0, in_flight} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (in_flight && (count == 2'd0 || (count == 2'd1 && pop))) begin
            entry0 <= incoming;
        end else if (pop) begin
            entry0 <= entry1;   // Head advances.
        end
        if (in_flight && ((count == 2'd1 && !pop) || (count == 2'd2 && pop))) begin
            entry1 <= incoming;
        end
    end

endmodule

/* framebuffer/framebuffer_ram.sv */
//////////////////////////////
// Contents are undefined after power-up.
// Read data lags the address by one cycle.
//////////////////////////////
`timescale 1ns/1ps

module framebuffer_ram (
    input  logic                clk,
    input  panel_pkg::ram_wr_t  wr,
    input  panel_pkg::fb_addr_u rd_addr,
    output logic [7:0]          rd_data
);

    localparam int DEPTH = 2 ** panel_pkg::ADDR_BITS;

    logic [7:0] mem [DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr.index] <= wr.data;
        end
    end

    // Registered read port.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr.index];
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the panel testbench with Verilator and runs it once.
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module panel_cmd_tb -Mdir "$BUILD_DIR" -o panel_cmd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/panel_cmd_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

/* tb/panel_cmd_properties.sv */
//////////////////////////////
// Stream checks on the top level. Sizes follow the bound instance.
//////////////////////////////
`timescale 1ns/1ps

module panel_cmd_properties #(
    parameter int PIXEL_HEIGHT    = 16,
    parameter int PIXEL_WIDTH     = 16,
    parameter int BYTES_PER_PIXEL = 3
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  cmd_ready,
    input logic                  scan_busy,
    input panel_pkg::scan_beat_t scan_out,
    input logic                  scan_valid,
    input logic                  scan_ready
);

    int failures = 0;

    // A stalled beat keeps its contents.
    beat_held: assert property (@(posedge clk) disable iff (reset)
        scan_valid && !scan_ready |=> $stable(scan_out))
        else begin
            $error("scan_out changed while the sink stalled");
            failures++;
        end

    valid_held: assert property (@(posedge clk) disable iff (reset)
        scan_valid && !scan_ready |=> scan_valid)
        else begin
            $error("scan_valid dropped without a transfer");
            failures++;
        end

    no_cmd_in_scan: assert property (@(posedge clk) disable iff (reset)
        scan_busy |-> !cmd_ready)
        else begin
            $error("cmd_ready high during a scan");
            failures++;
        end

    addr_in_range: assert property (@(posedge clk) disable iff (reset)
        scan_valid |-> (int'(scan_out.addr.fields.row) < PIXEL_HEIGHT)
            && (int'(scan_out.addr.fields.col) < PIXEL_WIDTH)
            && (int'(scan_out.addr.fields.pix_byte) < BYTES_PER_PIXEL))
        else begin
            $error("scan beat address outside the frame");
            failures++;
        end

endmodule

bind panel_cmd_top panel_cmd_properties #(
    .PIXEL_HEIGHT(PIXEL_HEIGHT), .PIXEL_WIDTH(PIXEL_WIDTH),
    .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
) i_properties (
    .clk(clk), .reset(reset), .cmd_ready(cmd_ready), .scan_busy(scan_busy),
    .scan_out(scan_out), .scan_valid(scan_valid), .scan_ready(scan_ready)
);

/* tb/panel_cmd_tb.sv */
//////////////////////////////
// 4x4 frame of 3-byte pixels. Seeded stimulus, so every run is the same.
//////////////////////////////
`timescale 1ns/1ps

module panel_cmd_tb;

    localparam int H        = 4;
    localparam int W        = 4;
    localparam int BPP      = 3;
    localparam int FRAME    = H * W * BPP;
    localparam int PERIOD   = 20;
    localparam int NUM_CMDS = 11;
    localparam int TIMEOUT  = (NUM_CMDS * FRAME + 200) * 4 * PERIOD;

    logic                  clk;
    logic                  reset;
    logic            [7:0] cmd_data;
    logic                  cmd_valid;
    logic                  cmd_ready;
    panel_pkg::scan_beat_t scan_out;
    logic                  scan_valid;
    logic                  scan_ready;

    logic [31:0] cmd_lfsr;
    logic [31:0] ready_lfsr;   // Separate stream for the sink.
    logic  [7:0] ref_frame [FRAME];
    logic        random_ready;
    logic        scan_done;
    int          beat_k;
    int          data_errors;
    int          addr_errors;
    int          last_errors;
    int          other_errors;

    panel_cmd_top #(.PIXEL_HEIGHT(H), .PIXEL_WIDTH(W), .BYTES_PER_PIXEL(BPP)) i_dut (
        .clk(clk), .reset(reset), .cmd_data(cmd_data), .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready), .scan_out(scan_out), .scan_valid(scan_valid),
        .scan_ready(scan_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Taps x^32 + x^22 + x^2 + x + 1. The new bit enters at the bottom.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            cmd_lfsr = lfsr_next(cmd_lfsr);
            value    = {value[6:0], cmd_lfsr[0]};
        end
    endtask

    // Returns on the falling edge before the byte is taken.
    task automatic send_byte(input logic [7:0] value);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            cmd_lfsr  = lfsr_next(cmd_lfsr);
            cmd_valid = cmd_lfsr[0];
            cmd_data  = value;
            accepted  = cmd_valid && cmd_ready;
        end
    endtask

    task automatic release_cmd();
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic load_frame();
        logic [7:0] value;
        send_byte(panel_pkg::OPC_LOAD_FRAME);
        for (int i = 0; i < FRAME; i++) begin
            draw_byte(value);
            send_byte(value);
            ref_frame[FRAME - 1 - i] = value;   // Highest address first.
        end
        release_cmd();
    endtask

    task automatic set_pixel(input logic [7:0] row, input logic [7:0] col);
        logic [7:0] value;
        send_byte(panel_pkg::OPC_SET_PIXEL);
        send_byte(row);
        send_byte(col);
        for (int b = 0; b < BPP; b++) begin
            draw_byte(value);
            send_byte(value);
            if (int'(row) < H && int'(col) < W) begin
                ref_frame[(int'(row) * W + int'(col)) * BPP + b] = value;
            end
        end
        release_cmd();
    endtask

    task automatic wait_scan_end();
        while (!scan_done) @(negedge clk);
        assert (beat_k == FRAME) else begin
            $display("%0t ns: scan ended after %0d beats instead of %0d", $time, beat_k, FRAME);
            other_errors++;
        end
    endtask

    task automatic run_show();
        send_byte(panel_pkg::OPC_SHOW);
        beat_k    = 0;
        scan_done = 1'b0;
        release_cmd();
        wait_scan_end();
    endtask

    task automatic stalled_show();
        send_byte(panel_pkg::OPC_SHOW);
        beat_k    = 0;
        scan_done = 1'b0;
        send_byte(panel_pkg::OPC_SHOW);   // Held off until the scan is over.
        assert (scan_done && beat_k == FRAME) else begin
            $display("%0t ns: a command was taken before the scan finished", $time);
            other_errors++;
        end
        beat_k    = 0;
        scan_done = 1'b0;
        release_cmd();
        wait_scan_end();
    endtask

    task automatic check_beat();
        panel_pkg::fb_addr_u exp_addr;
        if (beat_k >= FRAME) begin
            $display("%0t ns: beat %0d arrived after the end of the frame", $time, beat_k);
            other_errors++;
        end else begin
            exp_addr.fields.row      = panel_pkg::row_addr_t'(beat_k / (W * BPP));
            exp_addr.fields.col      = panel_pkg::col_addr_t'((beat_k / BPP) % W);
            exp_addr.fields.pix_byte = panel_pkg::byte_addr_t'(beat_k % BPP);
            assert (scan_out.addr == exp_addr) else begin
                $display("ERROR %0t ns: scan_out.addr expected %03h got %03h",
                         $time, exp_addr.index, scan_out.addr.index);
                addr_errors++;
            end
            assert (scan_out.data == ref_frame[beat_k]) else begin
                $display("ERROR %0t ns: scan_out.data expected %02h got %02h",
                         $time, ref_frame[beat_k], scan_out.data);
                data_errors++;
            end
            assert (scan_out.last == (beat_k == FRAME - 1)) else begin
                $display("ERROR %0t ns: scan_out.last expected %0b got %0b",
                         $time, beat_k == FRAME - 1, scan_out.last);
                last_errors++;
            end
        end
        if (scan_out.last) scan_done = 1'b1;
        beat_k++;
    endtask

    //////////////////////////////
    // Sink side. A beat seen here transfers on the next rising edge.
    //////////////////////////////
    always @(negedge clk) begin
        if (random_ready) begin
            ready_lfsr = lfsr_next(ready_lfsr);
            scan_ready = ready_lfsr[0];
        end else begin
            scan_ready = 1'b1;
        end
        if (!reset && scan_valid && scan_ready) check_beat();
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the DUT stopped making progress");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        cmd_data     = '0;
        cmd_valid    = 1'b0;
        scan_ready   = 1'b0;
        cmd_lfsr     = 32'h900e;
        ready_lfsr   = 32'h900e;
        random_ready = 1'b0;
        scan_done    = 1'b0;
        beat_k       = 0;
        data_errors  = 0;
        addr_errors  = 0;
        last_errors  = 0;
        other_errors = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        load_frame();
        run_show();
        set_pixel(8'd2, 8'd1);
        run_show();
        set_pixel(8'd7, 8'd0);   // Row out of range.
        set_pixel(8'd34, 8'd1);  // Row field would wrap to 2.
        send_byte(8'h55);
        release_cmd();
        run_show();
        random_ready = 1'b1;
        run_show();
        stalled_show();

        $display("Errors: data %0d, address %0d, last %0d, other %0d, property %0d",
                 data_errors, addr_errors, last_errors, other_errors,
                 i_dut.i_properties.failures);
        if (data_errors + addr_errors + last_errors + other_errors
                + i_dut.i_properties.failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog/cmd_dispatch.sv */
//////////////////////////////
// Unknown opcodes are dropped. Input stalls during scan-out.
//////////////////////////////
`timescale 1ns/1ps

module cmd_dispatch (
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         cmd_data,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    output logic [7:0]         byte_data,
    output logic               loader_enable,
    output logic               writer_enable,
    input  logic               loader_done,
    input  logic               writer_done,
    input  panel_pkg::ram_wr_t loader_wr,
    input  panel_pkg::ram_wr_t writer_wr,
    output panel_pkg::ram_wr_t wr,
    output logic               scan_start,
    input  logic               scan_busy
);

    typedef enum logic [1:0] {
        AWAIT_OPCODE,
        ROUTE_LOADER,
        ROUTE_WRITER,
        WAIT_SCAN
    } state_t;

    state_t state;
    state_t state_next;
    logic   ready_q;
    logic   accept;
    logic   opcode_slot;

    assign cmd_ready = ready_q;
    assign accept    = cmd_valid && ready_q;
    assign byte_data = cmd_data;

    // A handler's done cycle already takes the next opcode.
    assign opcode_slot = (state == AWAIT_OPCODE)
        || (state == ROUTE_LOADER && loader_done)
        || (state == ROUTE_WRITER && writer_done);

    assign loader_enable = accept && state == ROUTE_LOADER && !loader_done;
    assign writer_enable = accept && state == ROUTE_WRITER && !writer_done;
    assign scan_start    = accept && opcode_slot && cmd_data == panel_pkg::OPC_SHOW;

    always_comb begin
        state_next = state;
        if (state == WAIT_SCAN) begin
            if (!scan_busy) state_next = AWAIT_OPCODE;
        end else if (opcode_slot) begin
            state_next = AWAIT_OPCODE;
            if (accept) begin
                case (cmd_data)
                    panel_pkg::OPC_LOAD_FRAME: state_next = ROUTE_LOADER;
                    panel_pkg::OPC_SET_PIXEL:  state_next = ROUTE_WRITER;
                    panel_pkg::OPC_SHOW:       state_next = WAIT_SCAN;
                    default:                   state_next = AWAIT_OPCODE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= AWAIT_OPCODE;
            ready_q <= 1'b0;
        end else begin
            state   <= state_next;
            ready_q <= (state_next != WAIT_SCAN);
        end
    end

    // Handler writes lag their byte by one cycle, still in the same state.
    always_comb begin
        case (state)
            ROUTE_LOADER: wr = loader_wr;
            ROUTE_WRITER: wr = writer_wr;
            default:      wr = '0;
        endcase
    end

endmodule

/* verilog/frame_loader.sv */
//////////////////////////////
// Takes exactly one full frame, written from the last address down.
//////////////////////////////
`timescale 1ns/1ps

module frame_loader #(
    parameter int PIXEL_HEIGHT    = 16,
    parameter int PIXEL_WIDTH     = 16,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         byte_data,
    input  logic               enable,
    output panel_pkg::ram_wr_t wr,
    output logic               done
);

    localparam panel_pkg::row_addr_t  ROW_LAST  = panel_pkg::row_addr_t'(PIXEL_HEIGHT - 1);
    localparam panel_pkg::col_addr_t  COL_LAST  = panel_pkg::col_addr_t'(PIXEL_WIDTH - 1);
    localparam panel_pkg::byte_addr_t BYTE_LAST =
        panel_pkg::byte_addr_t'(BYTES_PER_PIXEL - 1);

    logic                loading;   // A frame is partly written.
    logic                wr_en;
    panel_pkg::fb_addr_u wr_addr;
    logic          [7:0] wr_data;
    panel_pkg::fb_addr_t next_addr;
    logic                last_byte;

    assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};

    //////////////////////////////
    // Address countdown.
    //////////////////////////////
    always_comb begin
        next_addr = wr_addr.fields;
        if (!loading) begin
            next_addr.row      = ROW_LAST;
            next_addr.col      = COL_LAST;
            next_addr.pix_byte = BYTE_LAST;
        end else if (wr_addr.fields.pix_byte != '0) begin
            next_addr.pix_byte = wr_addr.fields.pix_byte - 1'b1;
        end else begin
            next_addr.pix_byte = BYTE_LAST;
            if (wr_addr.fields.col == '0) begin
                next_addr.col = COL_LAST;
                next_addr.row = wr_addr.fields.row - 1'b1;
            end else begin
                next_addr.col = wr_addr.fields.col - 1'b1;
            end
        end
    end

    assign last_byte = (next_addr == '0);   // Address zero closes the frame.

    always_ff @(posedge clk) begin
        if (reset) begin
            loading <= 1'b0;
            wr_en   <= 1'b0;
            done    <= 1'b0;
        end else begin
            wr_en <= enable;
            done  <= enable && last_byte;
            if (enable) loading <= !last_byte;
        end
    end

    // Write payload follows the accepted byte.
    always_ff @(posedge clk) begin
        if (enable) begin
            wr_addr.fields <= next_addr;
            wr_data        <= byte_data;
        end
    end

endmodule

/* verilog/panel_cmd_top.sv */
//////////////////////////////
// Sizes must fit the field widths of panel_pkg.
// Commands stall while a frame is scanned out.
//////////////////////////////
`timescale 1ns/1ps

module panel_cmd_top #(
    parameter int PIXEL_HEIGHT    = 16,
    parameter int PIXEL_WIDTH     = 16,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [7:0]            cmd_data,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output panel_pkg::scan_beat_t scan_out,
    output logic                  scan_valid,
    input  logic                  scan_ready
);

    logic                 [7:0] byte_data;
    logic                       loader_enable;
    logic                       writer_enable;
    logic                       loader_done;
    logic                       writer_done;
    panel_pkg::ram_wr_t         loader_wr;
    panel_pkg::ram_wr_t         writer_wr;
    panel_pkg::ram_wr_t         wr;
    logic                       scan_start;
    logic                       scan_busy;
    panel_pkg::fb_addr_u        rd_addr;
    logic                 [7:0] rd_data;

    //////////////////////////////
    // Command side.
    //////////////////////////////
    cmd_dispatch i_dispatch (
        .clk(clk), .reset(reset),
        .cmd_data(cmd_data), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .byte_data(byte_data),
        .loader_enable(loader_enable), .writer_enable(writer_enable),
        .loader_done(loader_done), .writer_done(writer_done),
        .loader_wr(loader_wr), .writer_wr(writer_wr), .wr(wr),
        .scan_start(scan_start), .scan_busy(scan_busy)
    );

    frame_loader #(
        .PIXEL_HEIGHT(PIXEL_HEIGHT), .PIXEL_WIDTH(PIXEL_WIDTH),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) i_loader (
        .clk(clk), .reset(reset), .byte_data(byte_data),
        .enable(loader_enable), .wr(loader_wr), .done(loader_done)
    );

    pixel_writer #(
        .PIXEL_HEIGHT(PIXEL_HEIGHT), .PIXEL_WIDTH(PIXEL_WIDTH),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) i_writer (
        .clk(clk), .reset(reset), .byte_data(byte_data),
        .enable(writer_enable), .wr(writer_wr), .done(writer_done)
    );

    //////////////////////////////
    // Memory and scan-out.
    //////////////////////////////
    framebuffer_ram i_ram (
        .clk(clk), .wr(wr), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    frame_scanout #(
        .PIXEL_HEIGHT(PIXEL_HEIGHT), .PIXEL_WIDTH(PIXEL_WIDTH),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) i_scanout (
        .clk(clk), .reset(reset), .start(scan_start), .busy(scan_busy),
        .rd_addr(rd_addr), .rd_data(rd_data),
        .scan_out(scan_out), .scan_valid(scan_valid), .scan_ready(scan_ready)
    );

endmodule

/* verilog/pixel_writer.sv */
//////////////////////////////
// Out-of-range pixels consume their bytes but write nothing.
//////////////////////////////
`timescale 1ns/1ps

module pixel_writer #(
    parameter int PIXEL_HEIGHT    = 16,
    parameter int PIXEL_WIDTH     = 16,
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         byte_data,
    input  logic               enable,
    output panel_pkg::ram_wr_t wr,
    output logic               done
);

    typedef enum logic [1:0] {GET_ROW, GET_COL, GET_COLOR} phase_t;

    phase_t                 phase;
    logic             [7:0] row_q;
    logic             [7:0] col_q;
    panel_pkg::byte_addr_t  pix_cnt;
    logic                   in_range;
    logic                   last_color;
    logic                   wr_en;
    panel_pkg::fb_addr_u    wr_addr;
    logic             [7:0] wr_data;

    assign in_range   = (row_q < PIXEL_HEIGHT) && (col_q < PIXEL_WIDTH);
    assign last_color = (pix_cnt == panel_pkg::byte_addr_t'(BYTES_PER_PIXEL - 1));
    assign wr         = '{en: wr_en, addr: wr_addr, data: wr_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            phase   <= GET_ROW;
            pix_cnt <= '0;
            wr_en   <= 1'b0;
            done    <= 1'b0;
        end else begin
            wr_en <= enable && phase == GET_COLOR && in_range;
            done  <= enable && phase == GET_COLOR && last_color;
            if (enable) begin
                case (phase)
                    GET_ROW: phase <= GET_COL;
                    GET_COL: begin
                        phase   <= GET_COLOR;
                        pix_cnt <= '0;
                    end
                    default: begin
                        pix_cnt <= pix_cnt + 1'b1;
                        if (last_color) phase <= GET_ROW;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable && phase == GET_ROW) row_q <= byte_data;
        if (enable && phase == GET_COL) col_q <= byte_data;
        if (enable && phase == GET_COLOR) begin
            wr_addr.fields <= '{row: panel_pkg::row_addr_t'(row_q),
                                col: panel_pkg::col_addr_t'(col_q),
                                pix_byte: pix_cnt};
            wr_data <= byte_data;
        end
    end

endmodule
